//--- gsharePkg.sv
// Shared widths, branch kinds and helper functions of the gshare direction predictor
// Modules take these by a wildcard import in their headers
package gsharePkg;

    localparam int pcWidth        = 32;
    localparam int ghrWidth       = 8;
    localparam int phtIndexWidth  = 11;     // 8 hashed bits over 3 PC bits
    localparam int phtDepth       = 2048;
    localparam int slotCount      = 8;      // Halfwords per fetch bundle
    localparam int slotIndexWidth = 3;
    localparam int rowWidth       = 16;     // One 2-bit counter per slot
    localparam int retireRate     = 2;

    // Resolved branch kinds, only condBr trains the table
    typedef enum logic [1:0] {
        condBr,
        jal,
        jalr,
        ret
    } branchTypeE;

    // Table index from a PC and a history
    function automatic logic [phtIndexWidth-1:0] gshareHash(
        input logic [ghrWidth-1:0] ghr,
        input logic [pcWidth-1:0]  pc
    );
        return {pc[11:4] ^ ghr, pc[3:1]};
    endfunction

    // Newest outcome enters at bit 0
    function automatic logic [ghrWidth-1:0] shiftHistory(
        input logic [ghrWidth-1:0] ghr,
        input logic                taken
    );
        return {ghr[ghrWidth-2:0], taken};
    endfunction

    // Saturating counter, first sighting starts weak
    function automatic logic [1:0] nextCounter(
        input logic [1:0] oldCount,
        input logic       taken,
        input logic       hit
    );
        if (!hit)
            return taken ? 2'd2 : 2'd1;
        if (taken)
            return (oldCount == 2'd3) ? 2'd3 : oldCount + 2'd1;
        return (oldCount == 2'd0) ? 2'd0 : oldCount - 2'd1;
    endfunction

endpackage

//--- phtRam.sv
// Simple dual-port RAM for one copy of the pattern history table
// One write port, one registered read port that returns old data on collision
`timescale 1ns/1ps

module phtRam import gsharePkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wrEn,
    input  logic [phtIndexWidth-1:0] wrAddr,
    input  logic [rowWidth-1:0]      wrData,
    input  logic [phtIndexWidth-1:0] rdAddr,
    output logic [rowWidth-1:0]      rdData
);

    logic [rowWidth-1:0] mem [phtDepth];

    always_ff @(posedge clk) begin
        if (wrEn)
            mem[wrAddr] <= wrData;
    end

    // Read first, so a same-cycle write is seen one cycle later
    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr];
    end

    // An unknown write address would corrupt an arbitrary row
    writeAddrKnown: assert property (
        @(posedge clk) disable iff (rst) wrEn |-> !$isunknown(wrAddr)
    ) else $error("phtRam write with unknown address");

endmodule

//--- patternTable.sv
// Pattern history table with a prediction copy and an update copy of the rows
// Holds the per-row valid bits and forms the prediction outputs
`timescale 1ns/1ps

module patternTable import gsharePkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     dpEnable,
    input  logic [pcWidth-1:0]       fetchPc,
    input  logic [ghrWidth-1:0]      nextGhr,
    input  logic [phtIndexWidth-1:0] updReadIndex,
    input  logic                     updWrEn,
    input  logic [phtIndexWidth-1:0] updWrIndex,
    input  logic [rowWidth-1:0]      updWrData,
    output logic [rowWidth-1:0]      updReadData,
    output logic                     updReadHit,
    output logic [rowWidth-1:0]      predCounters,
    output logic                     predHit
);

    logic [phtIndexWidth-1:0] predIndex;
    logic [rowWidth-1:0]      respData;
    logic [phtDepth-1:0]      validBits;

    // Index uses the history that is registered at this edge
    assign predIndex = gshareHash(nextGhr, fetchPc);

    //**********************************************************
    // Two copies share every write
    //**********************************************************
    phtRam respPht (
        .clk    (clk),
        .rst    (rst),
        .wrEn   (updWrEn),
        .wrAddr (updWrIndex),
        .wrData (updWrData),
        .rdAddr (predIndex),
        .rdData (respData)
    );

    phtRam updPht (
        .clk    (clk),
        .rst    (rst),
        .wrEn   (updWrEn),
        .wrAddr (updWrIndex),
        .wrData (updWrData),
        .rdAddr (updReadIndex),
        .rdData (updReadData)
    );

    // Row becomes valid at its first write
    always_ff @(posedge clk) begin
        if (rst)
            validBits <= '0;
        else if (updWrEn)
            validBits[updWrIndex] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst)
            predHit <= 1'b0;
        else
            predHit <= validBits[predIndex];    // Aligned with respData
    end

    assign updReadHit   = validBits[updReadIndex];
    assign predCounters = dpEnable ? respData : '0;

endmodule

//--- historyRegs.sv
// Speculative, resolved and commit global history registers
// nextGhr is the speculative value about to be registered, used for the prediction index
`timescale 1ns/1ps

module historyRegs import gsharePkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  checkValid,
    input  logic [slotCount-1:0]  checkBranchMask,
    input  logic [slotCount-1:0]  checkTakenMask,
    input  logic                  resolveValid,
    input  branchTypeE            resolveType,
    input  logic                  resolveTaken,
    input  logic                  resolveMispredict,
    input  logic [retireRate-1:0] commitMask,
    input  logic [retireRate-1:0] commitTaken,
    input  logic                  commitLoad,
    output logic [ghrWidth-1:0]   nextGhr,
    output logic [ghrWidth-1:0]   resolvedGhr
);

    logic [ghrWidth-1:0] specGhr;
    logic [ghrWidth-1:0] commitGhr;
    logic [ghrWidth-1:0] checkGhr;
    logic [ghrWidth-1:0] commitNext;
    logic                condResolve;

    assign condResolve = resolveValid && (resolveType == condBr);

    //**********************************************************
    // Next-state logic
    //**********************************************************

    // Checker slots, lowest index is the oldest branch
    always_comb begin
        checkGhr = specGhr;
        for (int i = 0; i < slotCount; i++) begin
            if (checkBranchMask[i])
                checkGhr = shiftHistory(checkGhr, checkTakenMask[i]);
        end
    end

    // Retired branches, lane 0 first
    always_comb begin
        commitNext = commitGhr;
        for (int i = 0; i < retireRate; i++) begin
            if (commitMask[i])
                commitNext = shiftHistory(commitNext, commitTaken[i]);
        end
    end

    // Recovery sources win over the checker
    always_comb begin
        if (commitLoad)
            nextGhr = commitGhr;
        else if (condResolve && resolveMispredict)
            nextGhr = shiftHistory(resolvedGhr, resolveTaken);  // Redo from resolved path
        else if (checkValid)
            nextGhr = checkGhr;
        else
            nextGhr = specGhr;
    end

    //**********************************************************
    // Registers
    //**********************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            specGhr     <= '0;
            resolvedGhr <= '0;
            commitGhr   <= '0;
        end else begin
            specGhr   <= nextGhr;
            commitGhr <= commitNext;
            if (condResolve)
                resolvedGhr <= shiftHistory(resolvedGhr, resolveTaken);
        end
    end

endmodule

//--- counterUpdate.sv
// Two-stage read-modify-write of the counter trained by a resolved conditional branch
// Stage one reads the row, stage two writes it back with one counter changed
`timescale 1ns/1ps

module counterUpdate import gsharePkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      resolveValid,
    input  logic [pcWidth-1:0]        resolvePc,
    input  branchTypeE                resolveType,
    input  logic                      resolveTaken,
    input  logic [slotIndexWidth-1:0] resolveSlot,
    input  logic [ghrWidth-1:0]       resolvedGhr,
    input  logic [rowWidth-1:0]       updReadData,
    input  logic                      updReadHit,
    output logic [phtIndexWidth-1:0]  updReadIndex,
    output logic                      updWrEn,
    output logic [phtIndexWidth-1:0]  updWrIndex,
    output logic [rowWidth-1:0]       updWrData
);

    logic                      condResolve;
    logic                      takenQ;
    logic [slotIndexWidth-1:0] slotQ;
    logic                      hitQ;

    assign condResolve  = resolveValid && (resolveType == condBr);
    assign updReadIndex = gshareHash(resolvedGhr, resolvePc);  // Read issued this cycle

    // Stage one
    always_ff @(posedge clk) begin
        if (rst)
            updWrEn <= 1'b0;
        else
            updWrEn <= condResolve;
    end

    always_ff @(posedge clk) begin
        if (condResolve) begin
            updWrIndex <= updReadIndex;
            takenQ     <= resolveTaken;
            slotQ      <= resolveSlot;
            hitQ       <= updReadHit;
        end
    end

    // Stage two, row data arrives from the RAM now
    always_comb begin
        updWrData = updReadData;
        updWrData[2*slotQ +: 2] = nextCounter(updReadData[2*slotQ +: 2], takenQ, hitQ);
    end

    // A resolve strobe must carry a known PC, slot and outcome
    resolveFieldsKnown: assert property (
        @(posedge clk) disable iff (rst)
            condResolve |-> !$isunknown({resolvePc, resolveSlot, resolveTaken})
    ) else $error("counterUpdate resolve with unknown fields");

endmodule

//--- directionPredictor.sv
// Top level of the gshare direction predictor
// Connects the history registers, the pattern table and the counter update pipeline
`timescale 1ns/1ps

module directionPredictor import gsharePkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dpEnable,
    input  logic [pcWidth-1:0]        fetchPc,
    output logic [rowWidth-1:0]       predCounters,
    output logic                      predHit,
    input  logic                      resolveValid,
    input  logic [pcWidth-1:0]        resolvePc,
    input  branchTypeE                resolveType,
    input  logic                      resolveTaken,
    input  logic                      resolveMispredict,
    input  logic [slotIndexWidth-1:0] resolveSlot,
    input  logic                      checkValid,
    input  logic [slotCount-1:0]      checkBranchMask,
    input  logic [slotCount-1:0]      checkTakenMask,
    input  logic [retireRate-1:0]     commitMask,
    input  logic [retireRate-1:0]     commitTaken,
    input  logic                      commitLoad
);

    logic [ghrWidth-1:0]      nextGhr;
    logic [ghrWidth-1:0]      resolvedGhr;
    logic [phtIndexWidth-1:0] updReadIndex;
    logic [rowWidth-1:0]      updReadData;
    logic                     updReadHit;
    logic                     updWrEn;
    logic [phtIndexWidth-1:0] updWrIndex;
    logic [rowWidth-1:0]      updWrData;

    historyRegs uHistory (
        .clk               (clk),
        .rst               (rst),
        .checkValid        (checkValid),
        .checkBranchMask   (checkBranchMask),
        .checkTakenMask    (checkTakenMask),
        .resolveValid      (resolveValid),
        .resolveType       (resolveType),
        .resolveTaken      (resolveTaken),
        .resolveMispredict (resolveMispredict),
        .commitMask        (commitMask),
        .commitTaken       (commitTaken),
        .commitLoad        (commitLoad),
        .nextGhr           (nextGhr),
        .resolvedGhr       (resolvedGhr)
    );

    patternTable uTable (
        .clk          (clk),
        .rst          (rst),
        .dpEnable     (dpEnable),
        .fetchPc      (fetchPc),
        .nextGhr      (nextGhr),
        .updReadIndex (updReadIndex),
        .updWrEn      (updWrEn),
        .updWrIndex   (updWrIndex),
        .updWrData    (updWrData),
        .updReadData  (updReadData),
        .updReadHit   (updReadHit),
        .predCounters (predCounters),
        .predHit      (predHit)
    );

    counterUpdate uUpdate (
        .clk          (clk),
        .rst          (rst),
        .resolveValid (resolveValid),
        .resolvePc    (resolvePc),
        .resolveType  (resolveType),
        .resolveTaken (resolveTaken),
        .resolveSlot  (resolveSlot),
        .resolvedGhr  (resolvedGhr),
        .updReadData  (updReadData),
        .updReadHit   (updReadHit),
        .updReadIndex (updReadIndex),
        .updWrEn      (updWrEn),
        .updWrIndex   (updWrIndex),
        .updWrData    (updWrData)
    );

endmodule

//--- predChecker.sv
// Reference model of the histories and counters that checks the DUT predictions
// Sampled on the falling edge, where inputs and outputs are stable
`timescale 1ns/1ps

module predChecker import gsharePkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dpEnable,
    input  logic [pcWidth-1:0]        fetchPc,
    input  logic                      predStrobe,
    input  logic [rowWidth-1:0]       predCounters,
    input  logic                      predHit,
    input  logic                      resolveValid,
    input  logic [pcWidth-1:0]        resolvePc,
    input  branchTypeE                resolveType,
    input  logic                      resolveTaken,
    input  logic                      resolveMispredict,
    input  logic [slotIndexWidth-1:0] resolveSlot,
    input  logic                      checkValid,
    input  logic [slotCount-1:0]      checkBranchMask,
    input  logic [slotCount-1:0]      checkTakenMask,
    input  logic [retireRate-1:0]     commitMask,
    input  logic [retireRate-1:0]     commitTaken,
    input  logic                      commitLoad,
    input  logic                      testDone,
    input  int                        testNum,
    output int                        errorCount,
    output int                        checkCount,
    output int                        reportCount
);

    logic [7:0]  specM, resM, comM, nxt;
    logic [15:0] rowM [int];
    logic [7:0]  knownM [int];                // Slots with a known count
    logic        pendValid;
    int          pendIdx;
    int          testErrors;

    function automatic logic [10:0] modelIndex(input logic [7:0] h, input logic [31:0] pc);
        return {pc[11:4] ^ h, pc[3:1]};
    endfunction

    function automatic logic [7:0] push(input logic [7:0] h, input logic b);
        return {h[6:0], b};
    endfunction

    task automatic fail(input string msg);
        $display("Error %0t: test %0d %s", $time, testNum, msg);
        errorCount++;
        testErrors++;
    endtask

    //************************************************************
    // Prediction compare, one cycle after the request
    //************************************************************
    task automatic comparePrediction();
        logic exists;
        exists = rowM.exists(pendIdx);
        checkCount++;
        if (predHit !== exists)
            fail($sformatf("predHit %0b, expected %0b", predHit, exists));
        if (!dpEnable && predCounters !== '0)
            fail($sformatf("predCounters %h while disabled", predCounters));
        if (dpEnable && exists) begin
            for (int s = 0; s < 8; s++) begin
                if (knownM[pendIdx][s] && predCounters[2*s +: 2] !== rowM[pendIdx][2*s +: 2])
                    fail($sformatf("slot %0d counter %0d, expected %0d", s,
                        predCounters[2*s +: 2], rowM[pendIdx][2*s +: 2]));
            end
        end
    endtask

    task automatic trainCounter();
        int          idx;
        int          s;
        logic [15:0] row;
        logic [1:0]  c;
        idx = int'(modelIndex(resM, resolvePc));
        s   = int'(resolveSlot);
        if (!rowM.exists(idx)) begin
            row = '0;
            row[2*s +: 2] = resolveTaken ? 2'd2 : 2'd1;    // Weak start
            rowM[idx]   = row;
            knownM[idx] = 8'(1 << s);
        end else if (knownM[idx][s]) begin
            row = rowM[idx];
            c   = row[2*s +: 2];
            if (resolveTaken)
                c = (c == 2'd3) ? c : c + 2'd1;
            else
                c = (c == 2'd0) ? c : c - 2'd1;
            row[2*s +: 2] = c;
            rowM[idx] = row;
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            specM = '0;
            resM  = '0;
            comM  = '0;
            pendValid = 1'b0;
            rowM.delete();
            knownM.delete();
        end else begin
            if (pendValid)
                comparePrediction();
            pendValid = 1'b0;
            // Speculative history by priority
            nxt = specM;
            if (commitLoad)
                nxt = comM;
            else if (resolveValid && resolveType == condBr && resolveMispredict)
                nxt = push(resM, resolveTaken);
            else if (checkValid)
                for (int i = 0; i < 8; i++)
                    if (checkBranchMask[i])
                        nxt = push(nxt, checkTakenMask[i]);
            if (predStrobe) begin
                pendIdx   = int'(modelIndex(nxt, fetchPc));
                pendValid = 1'b1;
            end
            if (resolveValid && resolveType == condBr) begin
                trainCounter();
                resM = push(resM, resolveTaken);
            end
            for (int i = 0; i < 2; i++)
                if (commitMask[i])
                    comM = push(comM, commitTaken[i]);
            specM = nxt;
            if (testDone) begin
                $display("Test %0d finished with %0d errors", testNum, testErrors);
                testErrors = 0;
                reportCount++;
            end
        end
    end

    initial begin
        errorCount  = 0;
        checkCount  = 0;
        reportCount = 0;
        testErrors  = 0;
    end

endmodule

//--- tbDirectionPredictor.sv
// Testbench of the gshare direction predictor, applies a stimulus table in a loop
// predChecker does all comparing and counts the errors
`timescale 1ns/1ps

module tbDirectionPredictor import gsharePkg::*; ();

    typedef enum logic [2:0] {opPredict, opResolve, opCheck, opCommit, opLoad} opE;

    typedef struct {
        opE          op;
        logic [31:0] pc;
        logic [2:0]  slot;
        branchTypeE  typ;
        logic        taken;
        logic        mis;
        logic [7:0]  mask;
        logic [7:0]  tmask;
        logic        en;
        int          test;
    } rowT;

    logic clk, rst, dpEnable, predStrobe, predHit, testDone;
    logic [31:0] fetchPc, resolvePc;
    logic [15:0] predCounters;
    logic resolveValid, resolveTaken, resolveMispredict, checkValid, commitLoad;
    branchTypeE resolveType;
    logic [2:0] resolveSlot;
    logic [7:0] checkBranchMask, checkTakenMask;
    logic [1:0] commitMask, commitTaken;
    int testNum, errorCount, checkCount, reportCount;
    rowT table_q[$];
    logic [31:0] rpc;
    int reports;
    logic timedOut;

    directionPredictor u_dut (.*);
    predChecker uChecker (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic addRow(input opE op, input logic [31:0] pc, input logic [2:0] slot,
                          input branchTypeE typ, input logic taken, input logic mis,
                          input logic [7:0] mask, input logic [7:0] tmask,
                          input logic en, input int test);
        rowT r;
        r = '{op, pc, slot, typ, taken, mis, mask, tmask, en, test};
        table_q.push_back(r);
    endtask

    task automatic applyRow(input rowT r);
        @(posedge clk);
        testNum           <= r.test;
        dpEnable          <= r.en;    // Held until the next row
        fetchPc           <= r.pc;
        resolvePc         <= r.pc;
        resolveSlot       <= r.slot;
        resolveType       <= r.typ;
        resolveTaken      <= r.taken;
        resolveMispredict <= r.mis;
        checkBranchMask   <= r.mask;
        checkTakenMask    <= r.tmask;
        commitMask        <= r.mask[1:0];
        commitTaken       <= r.tmask[1:0];
        predStrobe        <= (r.op == opPredict);
        resolveValid      <= (r.op == opResolve);
        checkValid        <= (r.op == opCheck);
        commitLoad        <= (r.op == opLoad);
        if (r.op != opCommit)
            commitMask <= 2'b00;
        @(posedge clk);
        {predStrobe, resolveValid, checkValid, commitLoad} <= 4'b0;
        commitMask <= 2'b00;
        repeat (2) @(posedge clk);    // Lets the table write land
    endtask

    // Ends a test and waits for the checker's line
    task automatic finishTest(input int test);
        int waited;
        testNum  <= test;
        testDone <= 1'b1;
        @(posedge clk);
        testDone <= 1'b0;
        reports++;
        waited = 0;
        while (reportCount < reports && waited < 50) begin
            @(posedge clk);
            waited++;
        end
        if (reportCount < reports) begin
            $display("Timed out waiting for the report of test %0d", test);
            timedOut = 1'b1;
        end
    endtask

    initial begin
        int waited;
        void'($urandom(32'hdeda_ac14));
        {rst, dpEnable, predStrobe, testDone, resolveValid, resolveTaken} = 6'b110000;
        {resolveMispredict, checkValid, commitLoad} = 3'b0;
        {fetchPc, resolvePc, resolveSlot, checkBranchMask, checkTakenMask} = '0;
        {commitMask, commitTaken} = '0;
        resolveType = condBr;
        testNum = 0;
        reports = 0;
        timedOut = 1'b0;
        rpc = $urandom & 32'h0000_fffe;
        // Reset, disable, first training
        addRow(opPredict, 32'h1230, 0, condBr, 0, 0, 0, 0, 1, 1);
        addRow(opPredict, 32'h1230, 0, condBr, 0, 0, 0, 0, 0, 1);
        addRow(opResolve, 32'h2344, 2, condBr, 0, 0, 0, 0, 1, 2);
        addRow(opPredict, 32'h2344, 0, condBr, 0, 0, 0, 0, 1, 2);
        addRow(opResolve, 32'h3456, 5, condBr, 1, 0, 0, 0, 1, 2);
        addRow(opPredict, 32'h3456, 0, condBr, 0, 0, 0, 0, 1, 2);
        addRow(opPredict, 32'h3456, 0, condBr, 0, 0, 0, 0, 0, 2);  // Trained row, disabled
        // Saturation up then down
        for (int i = 0; i < 11; i++)
            addRow(opResolve, 32'h4562, 1, condBr, 1, 0, 0, 0, 1, 3);
        addRow(opCheck, 0, 0, condBr, 0, 0, 8'hff, 8'hff, 1, 3);
        addRow(opPredict, 32'h4562, 0, condBr, 0, 0, 0, 0, 1, 3);
        for (int i = 0; i < 11; i++)
            addRow(opResolve, 32'h567a, 6, condBr, 0, 0, 0, 0, 1, 3);
        addRow(opCheck, 0, 0, condBr, 0, 0, 8'hff, 8'h00, 1, 3);
        addRow(opPredict, 32'h567a, 0, condBr, 0, 0, 0, 0, 1, 3);
        // Checker masks select the trained history
        addRow(opResolve, 32'h6784, 1, condBr, 1, 0, 0, 0, 1, 4);
        addRow(opCheck, 0, 0, condBr, 0, 0, 8'h01, 8'h01, 1, 4);
        addRow(opPredict, 32'h6784, 0, condBr, 0, 0, 0, 0, 1, 4);
        addRow(opResolve, 32'h789c, 3, condBr, 1, 0, 0, 0, 1, 4);
        addRow(opPredict, 32'h789c, 0, condBr, 0, 0, 0, 0, 1, 4);
        addRow(opCheck, 0, 0, condBr, 0, 0, 8'h24, 8'h20, 1, 4);
        addRow(opPredict, 32'h08dc, 0, condBr, 0, 0, 0, 0, 1, 4);  // Hits only in slot order
        // Recovery paths
        addRow(opResolve, 32'h89a2, 0, condBr, 1, 1, 0, 0, 1, 5);
        addRow(opPredict, 32'h08fc, 0, condBr, 0, 0, 0, 0, 1, 5);
        addRow(opResolve, rpc ^ 32'h0ff0, 4, jal, 1, 1, 0, 0, 1, 5);
        addRow(opPredict, 32'h08fc, 0, condBr, 0, 0, 0, 0, 1, 5);
        addRow(opCommit, 0, 0, condBr, 0, 0, 8'h03, 8'h02, 1, 5);
        addRow(opLoad, 0, 0, condBr, 0, 0, 0, 0, 1, 5);
        addRow(opPredict, 32'h789c, 0, condBr, 0, 0, 0, 0, 1, 5);

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        waited = 0;
        while ((rst || predHit !== 1'b0) && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (rst || predHit !== 1'b0) begin
            $display("Timed out waiting for the predictor to leave reset");
            timedOut = 1'b1;
        end
        foreach (table_q[i]) begin
            if (!timedOut) begin
                applyRow(table_q[i]);
                if (i == table_q.size() - 1 || table_q[i+1].test != table_q[i].test)
                    finishTest(table_q[i].test);
            end
        end
        $display("%0d tests, %0d checks, %0d errors", reports, checkCount, errorCount);
        if (!timedOut && errorCount == 0 && checkCount > 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

//--- gsharePredictor.f
gsharePkg.sv
phtRam.sv
patternTable.sv
historyRegs.sv
counterUpdate.sv
directionPredictor.sv
predChecker.sv
tbDirectionPredictor.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f gsharePredictor.f \
    --top-module tbDirectionPredictor -o simv > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    || echo "Build or simulation ended with an error"
grep -qx "test passed" sim.log && echo "PASS" && exit 0 || echo "FAIL" && exit 1
